// File: Bender.yml
package:
  name: breakout

sources:
  - source/breakout_pkg.sv
  - source/game_phase.sv
  - source/paddle_ctrl.sv
  - source/ball_physics.sv
  - source/brick_wall.sv
  - source/pixel_renderer.sv
  - source/breakout_top.sv
  - target: test
    files:
      - tests/breakout_props.sv
      - tests/breakout_tb.sv

// File: flist.f
source/breakout_pkg.sv
source/game_phase.sv
source/paddle_ctrl.sv
source/ball_physics.sv
source/brick_wall.sv
source/pixel_renderer.sv
source/breakout_top.sv
tests/breakout_props.sv
tests/breakout_tb.sv

// File: source/ball_physics.sv
`timescale 1ns/1ns

module ball_physics import breakout_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   step,
    input  coord_t paddle_x,
    input  logic   bounce_x,
    input  logic   bounce_y,
    output ball_t  ball,
    output coord_t ball_prev_x,
    output logic   ball_lost
);

    logic              paddle_hit;
    logic signed [10:0] offset;
    logic        [10:0] abs_offset;
    logic        [3:0]  angle_idx;

    assign ball_lost = ball.y >= coord_t'(INNER_MAX_Y);

    // Paddle contact box and angle from the signed center offset
    always_comb begin
        paddle_hit = (ball.y >= coord_t'(PADDLE_Y - BALL_RADIUS)) &&
                     (ball.y <= coord_t'(PADDLE_Y + PADDLE_R)) &&
                     (int'(ball.x) + PADDLE_HALF >= int'(paddle_x)) &&
                     (int'(ball.x) <= int'(paddle_x) + PADDLE_HALF);
        offset = $signed({1'b0, ball.x}) - $signed({1'b0, paddle_x});
        abs_offset = offset[10] ? 11'(-offset) : 11'(offset);
        angle_idx = 4'd8;
        for (int i = 7; i >= 0; i--) begin
            if (int'(abs_offset) <= ANGLE_LIMIT[i]) begin
                angle_idx = 4'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ball.x      <= coord_t'(BALL_X0);
            ball.y      <= coord_t'(BALL_Y0);
            ball.vx_mag <= 5'(INIT_VX);
            ball.vy_mag <= 5'(INIT_VY);
            ball.vx_dir <= 1'b1;
            ball.vy_dir <= 1'b1;
            ball_prev_x <= coord_t'(BALL_X0);
        end else if (step) begin
            ball_prev_x <= ball.x;

            // Later assignments override earlier ones
            if (ball.vx_dir) begin
                ball.x <= ball.x + coord_t'(ball.vx_mag);
            end else begin
                ball.x <= ball.x - coord_t'(ball.vx_mag);
            end
            if (ball.vy_dir) begin
                ball.y <= ball.y + coord_t'(ball.vy_mag);
            end else begin
                ball.y <= ball.y - coord_t'(ball.vy_mag);
            end

            if (ball.x <= coord_t'(INNER_MIN_X)) begin
                ball.vx_dir <= 1'b1;
            end else if (ball.x >= coord_t'(INNER_MAX_X)) begin
                ball.vx_dir <= 1'b0;
            end
            if (ball.y <= coord_t'(INNER_MIN_Y)) begin
                ball.vy_dir <= 1'b1;
            end else if (ball.y >= coord_t'(INNER_MAX_Y)) begin
                ball.vy_dir <= 1'b0;
            end

            if (paddle_hit) begin
                ball.y      <= coord_t'(PADDLE_Y - BALL_RADIUS - 1);
                ball.vy_dir <= 1'b0;
                ball.vx_dir <= offset > 0;
                ball.vx_mag <= ANGLE_VX[angle_idx];
                ball.vy_mag <= ANGLE_VY[angle_idx];
            end

            // Brick hits flip the direction held before this step
            if (bounce_x) begin
                ball.vx_dir <= ~ball.vx_dir;
            end
            if (bounce_y) begin
                ball.vy_dir <= ~ball.vy_dir;
            end
        end
    end

endmodule

// File: source/breakout_pkg.sv
package breakout_pkg;

    localparam int COORD_W = 10;

    typedef logic [COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   active;
    } pixel_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic start;
        logic left;
        logic right;
        logic pause;
    } ctrl_t;

    // vx_dir set means moving right and vy_dir set means moving down
    typedef struct packed {
        coord_t     x;
        coord_t     y;
        logic [4:0] vx_mag;
        logic [4:0] vy_mag;
        logic       vx_dir;
        logic       vy_dir;
    } ball_t;

    typedef struct packed {
        logic       on;
        logic [2:0] row;
    } brick_px_t;

    localparam int FRAME_X0    = 221;
    localparam int FRAME_Y0    = 86;
    localparam int FRAME_W     = 350;
    localparam int FRAME_H     = 350;
    localparam int FRAME_THICK = 3;

    localparam int BALL_RADIUS = 6;
    localparam int BALL_R2     = BALL_RADIUS * BALL_RADIUS;
    localparam int BALL_X0     = FRAME_X0 + 150;
    localparam int BALL_Y0     = FRAME_Y0 + 200;
    localparam int INIT_VX     = 0;
    localparam int INIT_VY     = 2;

    // Ball center limits inside the frame
    localparam int INNER_MIN_X = FRAME_X0 + FRAME_THICK + BALL_RADIUS;
    localparam int INNER_MAX_X = FRAME_X0 + FRAME_W - FRAME_THICK - BALL_RADIUS;
    localparam int INNER_MIN_Y = FRAME_Y0 + FRAME_THICK + BALL_RADIUS;
    localparam int INNER_MAX_Y = FRAME_Y0 + FRAME_H - FRAME_THICK - BALL_RADIUS;

    localparam int PADDLE_W         = 80;
    localparam int PADDLE_H         = 10;
    localparam int PADDLE_HALF      = PADDLE_W / 2;
    localparam int PADDLE_R         = PADDLE_H / 2;
    localparam int PADDLE_RECT_HALF = PADDLE_HALF - PADDLE_R;
    localparam int PADDLE_MARGIN    = 8;
    localparam int MOVE_STEP        = 4;
    // Paddle starts right under the ball
    localparam int PADDLE_X0        = BALL_X0;
    localparam int PADDLE_Y = FRAME_Y0 + FRAME_H - FRAME_THICK - PADDLE_MARGIN - PADDLE_R;
    localparam int PADDLE_MIN_CX    = FRAME_X0 + FRAME_THICK + PADDLE_HALF;
    localparam int PADDLE_MAX_CX    = FRAME_X0 + FRAME_W - FRAME_THICK - PADDLE_HALF;

    // Brick offsets from the inner frame corner
    localparam int BRICK_W    = 40;
    localparam int BRICK_H    = 15;
    localparam int BRICK_ROWS = 5;
    localparam int BRICK_COLS = 5;
    localparam int BRICK_X_OFF [BRICK_COLS] = '{30, 80, 130, 180, 230};
    localparam int BRICK_Y_OFF [BRICK_ROWS] = '{20, 40, 60, 80, 100};

    // Paddle hit angle indexed by the first threshold not below |offset|
    localparam int         ANGLE_LIMIT [8] = '{2, 6, 10, 14, 18, 22, 26, 30};
    localparam logic [4:0] ANGLE_VX [9] = '{0, 1, 2, 3, 4, 5, 6, 7, 8};
    localparam logic [4:0] ANGLE_VY [9] = '{4, 4, 4, 3, 3, 3, 2, 2, 1};

    localparam rgb_t COLOR_BG     = 24'h000000;
    localparam rgb_t COLOR_FRAME  = 24'h4BA3C3;
    localparam rgb_t COLOR_BALL   = 24'hFF0000;
    localparam rgb_t COLOR_PADDLE = 24'hFFFFFF;
    localparam rgb_t COLOR_START  = 24'h202040;
    localparam rgb_t COLOR_OVER   = 24'h800000;
    localparam rgb_t COLOR_ROW [BRICK_ROWS] = '{
        24'hFFADAD, 24'hFDFFB6, 24'hCAFFBF, 24'h9BF6FF, 24'hBDB2FF
    };

endpackage

// File: source/breakout_top.sv
`timescale 1ns/1ns

module breakout_top import breakout_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  ctrl_t  ctrl,
    input  logic   vsync,
    input  pixel_t px,
    output rgb_t   rgb,
    output logic   started,
    output logic   over
);

    logic      step;
    coord_t    paddle_x;
    ball_t     ball;
    coord_t    ball_prev_x;
    logic      ball_lost;
    logic      bounce_x;
    logic      bounce_y;
    brick_px_t brick_px;

    game_phase u_phase (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .vsync     (vsync),
        .ball_lost (ball_lost),
        .step      (step),
        .started   (started),
        .over      (over)
    );

    paddle_ctrl u_paddle (
        .clk      (clk),
        .rst      (rst),
        .step     (step),
        .ctrl     (ctrl),
        .paddle_x (paddle_x)
    );

    ball_physics u_ball (
        .clk         (clk),
        .rst         (rst),
        .step        (step),
        .paddle_x    (paddle_x),
        .bounce_x    (bounce_x),
        .bounce_y    (bounce_y),
        .ball        (ball),
        .ball_prev_x (ball_prev_x),
        .ball_lost   (ball_lost)
    );

    brick_wall u_bricks (
        .clk         (clk),
        .rst         (rst),
        .step        (step),
        .ball        (ball),
        .ball_prev_x (ball_prev_x),
        .px          (px),
        .bounce_x    (bounce_x),
        .bounce_y    (bounce_y),
        .brick_px    (brick_px)
    );

    pixel_renderer u_render (
        .clk      (clk),
        .rst      (rst),
        .px       (px),
        .started  (started),
        .over     (over),
        .ball     (ball),
        .paddle_x (paddle_x),
        .brick_px (brick_px),
        .rgb      (rgb)
    );

endmodule

// File: source/brick_wall.sv
`timescale 1ns/1ns

module brick_wall import breakout_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      step,
    input  ball_t     ball,
    input  coord_t    ball_prev_x,
    input  pixel_t    px,
    output logic      bounce_x,
    output logic      bounce_y,
    output brick_px_t brick_px
);

    localparam int NUM_BRICKS = BRICK_ROWS * BRICK_COLS;

    logic [NUM_BRICKS-1:0] alive;
    logic [NUM_BRICKS-1:0] hit;

    // Ball against every live brick
    always_comb begin
        int  bx0;
        int  by0;
        logic prev_out;
        hit      = '0;
        bounce_x = 1'b0;
        bounce_y = 1'b0;
        for (int r = 0; r < BRICK_ROWS; r++) begin
            for (int c = 0; c < BRICK_COLS; c++) begin
                bx0 = FRAME_X0 + FRAME_THICK + BRICK_X_OFF[c];
                by0 = FRAME_Y0 + FRAME_THICK + BRICK_Y_OFF[r];
                hit[r*BRICK_COLS+c] = alive[r*BRICK_COLS+c] &&
                    (int'(ball.x) + BALL_RADIUS >= bx0) &&
                    (int'(ball.x) - BALL_RADIUS <= bx0 + BRICK_W) &&
                    (int'(ball.y) + BALL_RADIUS >= by0) &&
                    (int'(ball.y) - BALL_RADIUS <= by0 + BRICK_H);
                // Came in from the side if the last x was clear of the brick
                prev_out = (int'(ball_prev_x) + BALL_RADIUS < bx0) ||
                           (int'(ball_prev_x) - BALL_RADIUS > bx0 + BRICK_W);
                if (hit[r*BRICK_COLS+c]) begin
                    bounce_x = bounce_x | prev_out;
                    bounce_y = bounce_y | ~prev_out;
                end
            end
        end
    end

    // Pixel lookup, lowest row and column first
    always_comb begin
        int bx0;
        int by0;
        brick_px = '0;
        for (int r = 0; r < BRICK_ROWS; r++) begin
            for (int c = 0; c < BRICK_COLS; c++) begin
                bx0 = FRAME_X0 + FRAME_THICK + BRICK_X_OFF[c];
                by0 = FRAME_Y0 + FRAME_THICK + BRICK_Y_OFF[r];
                if (!brick_px.on && alive[r*BRICK_COLS+c] &&
                    (int'(px.x) >= bx0) && (int'(px.x) < bx0 + BRICK_W) &&
                    (int'(px.y) >= by0) && (int'(px.y) < by0 + BRICK_H)) begin
                    brick_px.on  = 1'b1;
                    brick_px.row = 3'(r);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            alive <= '1;
        end else if (step) begin
            alive <= alive & ~hit;
        end
    end

endmodule

// File: source/game_phase.sv
`timescale 1ns/1ns

module game_phase import breakout_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  ctrl_t ctrl,
    input  logic  vsync,
    input  logic  ball_lost,
    output logic  step,
    output logic  started,
    output logic  over
);

    logic vsync_q;
    logic frame_edge;

    assign frame_edge = vsync & ~vsync_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vsync_q <= 1'b0;
            step    <= 1'b0;
            started <= 1'b0;
            over    <= 1'b0;
        end else begin
            vsync_q <= vsync;
            // One step per frame, only while the game is running
            step    <= frame_edge & started & ~over & ~ctrl.pause;
            if (ctrl.start) begin
                started <= 1'b1;
            end
            if (step && ball_lost) begin
                over <= 1'b1;
            end
        end
    end

endmodule

// File: source/paddle_ctrl.sv
`timescale 1ns/1ns

module paddle_ctrl import breakout_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   step,
    input  ctrl_t  ctrl,
    output coord_t paddle_x
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            paddle_x <= coord_t'(PADDLE_X0);
        end else if (step) begin
            // Left wins when both keys are held
            if (ctrl.left) begin
                if (paddle_x > coord_t'(PADDLE_MIN_CX + MOVE_STEP)) begin
                    paddle_x <= paddle_x - coord_t'(MOVE_STEP);
                end else begin
                    paddle_x <= coord_t'(PADDLE_MIN_CX);
                end
            end else if (ctrl.right) begin
                if (paddle_x < coord_t'(PADDLE_MAX_CX - MOVE_STEP)) begin
                    paddle_x <= paddle_x + coord_t'(MOVE_STEP);
                end else begin
                    paddle_x <= coord_t'(PADDLE_MAX_CX);
                end
            end
        end
    end

endmodule

// File: source/pixel_renderer.sv
`timescale 1ns/1ns

module pixel_renderer import breakout_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  pixel_t    px,
    input  logic      started,
    input  logic      over,
    input  ball_t     ball,
    input  coord_t    paddle_x,
    input  brick_px_t brick_px,
    output rgb_t      rgb
);

    logic        in_frame;
    logic        in_inner;
    logic        on_ball;
    logic        on_paddle;
    coord_t      bdx;
    coord_t      bdy;
    coord_t      adx;
    coord_t      ady;
    coord_t      ex;
    logic [20:0] ball_d2;
    logic [20:0] cap_d2;
    rgb_t        color;

    function automatic coord_t absdiff(coord_t a, coord_t b);
        return (a >= b) ? a - b : b - a;
    endfunction

    always_comb begin
        in_frame = (int'(px.x) >= FRAME_X0) && (int'(px.x) < FRAME_X0 + FRAME_W) &&
                   (int'(px.y) >= FRAME_Y0) && (int'(px.y) < FRAME_Y0 + FRAME_H);
        in_inner = (int'(px.x) >= FRAME_X0 + FRAME_THICK) &&
                   (int'(px.x) < FRAME_X0 + FRAME_W - FRAME_THICK) &&
                   (int'(px.y) >= FRAME_Y0 + FRAME_THICK) &&
                   (int'(px.y) < FRAME_Y0 + FRAME_H - FRAME_THICK);

        bdx     = absdiff(px.x, ball.x);
        bdy     = absdiff(px.y, ball.y);
        ball_d2 = 21'(bdx) * 21'(bdx) + 21'(bdy) * 21'(bdy);
        on_ball = ball_d2 <= 21'(BALL_R2);

        // Capsule is a rectangle with half-disc caps at both ends
        adx    = absdiff(px.x, paddle_x);
        ady    = absdiff(px.y, coord_t'(PADDLE_Y));
        ex     = (adx > coord_t'(PADDLE_RECT_HALF)) ? adx - coord_t'(PADDLE_RECT_HALF) : '0;
        cap_d2 = 21'(ex) * 21'(ex) + 21'(ady) * 21'(ady);
        on_paddle = (adx <= coord_t'(PADDLE_HALF)) && (ady <= coord_t'(PADDLE_R)) &&
                    (cap_d2 <= 21'(PADDLE_R * PADDLE_R));

        if (!px.active) begin
            color = '0;
        end else if (!started) begin
            color = COLOR_START;
        end else if (over) begin
            color = COLOR_OVER;
        end else if (in_frame && !in_inner) begin
            color = COLOR_FRAME;
        end else if (on_ball) begin
            color = COLOR_BALL;
        end else if (on_paddle) begin
            color = COLOR_PADDLE;
        end else if (brick_px.on) begin
            color = COLOR_ROW[brick_px.row];
        end else begin
            color = COLOR_BG;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rgb <= '0;
        end else begin
            rgb <= color;
        end
    end

endmodule

// File: tests/breakout_props.sv
`timescale 1ns/1ns

module breakout_props import breakout_pkg::*; (
    input logic   clk,
    input logic   rst,
    input pixel_t px,
    input rgb_t   rgb,
    input logic   started,
    input logic   over
);

    int prop_errors = 0;

    over_needs_start: assert property (@(posedge clk) disable iff (!rst) over |-> started)
        else begin
            $error("over is high while started is low");
            prop_errors++;
        end

    // Start latch only clears through reset
    started_holds: assert property (@(posedge clk) disable iff (!rst) started |=> started)
        else begin
            $error("started fell without a reset");
            prop_errors++;
        end

    inactive_black: assert property (@(posedge clk) disable iff (!rst) !px.active |=> rgb == '0)
        else begin
            $error("rgb not black after an inactive pixel");
            prop_errors++;
        end

endmodule

bind breakout_top breakout_props u_props (.*);

// File: tests/breakout_tb.sv
`timescale 1ns/1ns

module breakout_tb import breakout_pkg::*; ();

    typedef enum int {M_CONST, M_PAD_L, M_PAD_R, M_BALL, M_BRICK5} probe_mode_t;

    typedef struct {
        string       name;
        bit          do_reset;
        int          frames;
        ctrl_t       keys;
        probe_mode_t mode;
        int          x;
        int          y;
        bit          active;
        rgb_t        color;
    } test_t;

    // Key bit order is start, left, right, pause
    localparam ctrl_t K_NONE  = 4'b0000;
    localparam ctrl_t K_START = 4'b1000;
    localparam ctrl_t K_LEFT  = 4'b0100;
    localparam ctrl_t K_RIGHT = 4'b0010;
    localparam ctrl_t K_HOLD  = 4'b0101;
    localparam rgb_t  BLACK   = 24'h000000;

    logic   clk;
    logic   rst;
    ctrl_t  ctrl;
    logic   vsync;
    pixel_t px;
    rgb_t   rgb;
    logic   started;
    logic   over;

    test_t tests[$];
    int    cycles = 0;
    int    cycle_limit;
    int    pass_count;
    int    fail_count;
    int    errs;

    // Reference game state with the ball fixed at x = BALL_X0
    int       model_y;
    int       model_vy;
    bit       model_down;
    int       model_paddle;
    bit       model_started;
    bit       model_over;
    bit [4:0] model_alive;

    breakout_top DUT (
        .clk     (clk),
        .rst     (rst),
        .ctrl    (ctrl),
        .vsync   (vsync),
        .px      (px),
        .rgb     (rgb),
        .started (started),
        .over    (over)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic void add_test(string name, bit do_reset, int frames, ctrl_t keys,
                                     probe_mode_t mode, int x, int y, bit active, rgb_t color);
        test_t t;
        t.name     = name;
        t.do_reset = do_reset;
        t.frames   = frames;
        t.keys     = keys;
        t.mode     = mode;
        t.x        = x;
        t.y        = y;
        t.active   = active;
        t.color    = color;
        tests.push_back(t);
    endfunction

    function automatic void fill_table();
        add_test("reset_start_screen", 1, 0, K_NONE, M_CONST, 400, 300, 1, COLOR_START);
        add_test("inactive_black", 0, 0, K_NONE, M_CONST, 400, 300, 0, BLACK);
        add_test("keys_before_start", 0, 3, K_RIGHT, M_CONST, 400, 300, 1, COLOR_START);
        add_test("start_border", 0, 1, K_START, M_CONST, 221, 200, 1, COLOR_FRAME);
        add_test("background", 0, 0, K_NONE, M_CONST, 300, 300, 1, COLOR_BG);
        add_test("brick_row1", 0, 0, K_NONE, M_CONST, 274, 116, 1, COLOR_ROW[0]);
        add_test("brick_row5", 0, 0, K_NONE, M_CONST, 274, 196, 1, COLOR_ROW[4]);
        add_test("paddle_center", 0, 0, K_NONE, M_CONST, PADDLE_X0, PADDLE_Y, 1, COLOR_PADDLE);
        add_test("ball_center", 0, 0, K_NONE, M_CONST, BALL_X0, BALL_Y0, 1, COLOR_BALL);
        add_test("right10_left_end", 0, 10, K_RIGHT, M_PAD_L, 0, 0, 1, BLACK);
        add_test("right10_right_end", 0, 0, K_NONE, M_PAD_R, 0, 0, 1, BLACK);
        add_test("right10_old_end", 0, 0, K_NONE, M_CONST, PADDLE_X0 - 39, PADDLE_Y, 1, COLOR_BG);
        add_test("clamp_right_end", 0, 35, K_RIGHT, M_PAD_R, 0, 0, 1, BLACK);
        add_test("clamp_left_end", 0, 0, K_NONE, M_PAD_L, 0, 0, 1, BLACK);
        add_test("pause_paddle", 0, 5, K_HOLD, M_PAD_R, 0, 0, 1, BLACK);
        add_test("pause_ball", 0, 0, K_NONE, M_BALL, 0, 0, 1, BLACK);
        add_test("center_restart", 1, 1, K_START, M_BALL, 0, 0, 1, BLACK);
        add_test("center_left_end", 0, 0, K_NONE, M_PAD_L, 0, 0, 1, BLACK);
        add_test("center_right_end", 0, 0, K_NONE, M_PAD_R, 0, 0, 1, BLACK);
        add_test("fall_and_bounce", 0, 70, K_NONE, M_BALL, 0, 0, 1, BLACK);
        add_test("brick_before_hit", 0, 40, K_NONE, M_BRICK5, 374, 196, 1, BLACK);
        add_test("brick_cleared", 0, 8, K_NONE, M_BRICK5, 374, 196, 1, BLACK);
        add_test("neighbor_brick", 0, 0, K_NONE, M_CONST, 324, 196, 1, COLOR_ROW[4]);
        add_test("ball_after_brick", 0, 0, K_NONE, M_BALL, 0, 0, 1, BLACK);
        add_test("lose_restart", 1, 1, K_START, M_BALL, 0, 0, 1, BLACK);
        add_test("lose_left_end", 0, 40, K_LEFT, M_PAD_L, 0, 0, 1, BLACK);
        add_test("lose_right_end", 0, 0, K_NONE, M_PAD_R, 0, 0, 1, BLACK);
        add_test("over_screen", 0, 35, K_NONE, M_CONST, 300, 300, 1, COLOR_OVER);
        add_test("over_border", 0, 0, K_NONE, M_CONST, 221, 200, 1, COLOR_OVER);
        add_test("over_inactive", 0, 0, K_NONE, M_CONST, 300, 300, 0, BLACK);
    endfunction

    // One frame step of ball, bricks and paddle
    function automatic void step_model(ctrl_t keys);
        int by0;
        int off;
        int abs_off;
        int idx;
        int next_y;
        bit next_down;
        bit hit;
        hit = 0;
        if (model_y >= INNER_MAX_Y) begin
            model_over = 1;
        end
        for (int r = 0; r < BRICK_ROWS; r++) begin
            by0 = FRAME_Y0 + FRAME_THICK + BRICK_Y_OFF[r];
            if (model_alive[r] && model_y + BALL_RADIUS >= by0 &&
                model_y - BALL_RADIUS <= by0 + BRICK_H) begin
                hit = 1;
                model_alive[r] = 0;
            end
        end
        next_y    = model_down ? model_y + model_vy : model_y - model_vy;
        next_down = model_down;
        if (model_y <= INNER_MIN_Y) begin
            next_down = 1;
        end else if (model_y >= INNER_MAX_Y) begin
            next_down = 0;
        end
        off     = BALL_X0 - model_paddle;
        abs_off = (off < 0) ? -off : off;
        if (model_y >= PADDLE_Y - BALL_RADIUS && model_y <= PADDLE_Y + PADDLE_R &&
            abs_off <= PADDLE_HALF) begin
            idx = 0;
            while (idx < 8 && abs_off > ANGLE_LIMIT[idx]) begin
                idx++;
            end
            next_y    = PADDLE_Y - BALL_RADIUS - 1;
            next_down = 0;
            model_vy  = ANGLE_VY[idx];
        end
        if (hit) begin
            next_down = !model_down;
        end
        model_y    = next_y;
        model_down = next_down;
        if (keys.left) begin
            model_paddle = (model_paddle - MOVE_STEP < PADDLE_MIN_CX) ?
                           PADDLE_MIN_CX : model_paddle - MOVE_STEP;
        end else if (keys.right) begin
            model_paddle = (model_paddle + MOVE_STEP > PADDLE_MAX_CX) ?
                           PADDLE_MAX_CX : model_paddle + MOVE_STEP;
        end
    endfunction

    task automatic apply_reset(string name);
        rst   = 1'b0;
        ctrl  = K_NONE;
        vsync = 1'b0;
        px    = '0;
        repeat (5) @(negedge clk);
        assert (rgb === BLACK && started === 1'b0 && over === 1'b0) else begin
            $display("** Error: %s in reset expected rgb %06h started 0 over 0, actual %06h %0b %0b",
                     name, BLACK, rgb, started, over);
            errs++;
        end
        rst           = 1'b1;
        model_y       = BALL_Y0;
        model_vy      = INIT_VY;
        model_down    = 1;
        model_paddle  = PADDLE_X0;
        model_started = 0;
        model_over    = 0;
        model_alive   = '1;
    endtask

    // vsync high for 2 cycles, low for 4
    task automatic run_frame(ctrl_t keys);
        bit stepping;
        stepping = model_started && !model_over && !keys.pause;
        vsync = 1'b1;
        repeat (2) @(negedge clk);
        vsync = 1'b0;
        repeat (4) @(negedge clk);
        if (stepping) begin
            step_model(keys);
        end
        if (keys.start) begin
            model_started = 1;
        end
    endtask

    task automatic probe_pixel(string name, int x, int y, bit active, rgb_t expected);
        px.x      = coord_t'(x);
        px.y      = coord_t'(y);
        px.active = active;
        @(negedge clk);
        assert (rgb === expected) else begin
            $display("** Error: %s at (%0d,%0d) expected %06h actual %06h",
                     name, x, y, expected, rgb);
            errs++;
        end
        px = '0;
    endtask

    task automatic run_test(test_t t);
        int   x;
        int   y;
        rgb_t expected;
        errs = 0;
        if (t.do_reset) begin
            apply_reset(t.name);
        end
        ctrl = t.keys;
        for (int f = 0; f < t.frames; f++) begin
            run_frame(t.keys);
            assert (started === model_started && over === model_over) else begin
                $display("** Error: %s frame %0d started/over expected %0b/%0b actual %0b/%0b",
                         t.name, f, model_started, model_over, started, over);
                errs++;
            end
        end
        x        = t.x;
        y        = t.y;
        expected = t.color;
        case (t.mode)
            M_PAD_L: begin
                x        = model_paddle - (PADDLE_HALF - 1);
                y        = PADDLE_Y;
                expected = COLOR_PADDLE;
            end
            M_PAD_R: begin
                x        = model_paddle + (PADDLE_HALF - 1);
                y        = PADDLE_Y;
                expected = COLOR_PADDLE;
            end
            M_BALL: begin
                x        = BALL_X0;
                y        = model_y;
                expected = COLOR_BALL;
            end
            M_BRICK5: expected = model_alive[4] ? COLOR_ROW[4] : COLOR_BG;
            default: expected = t.color;
        endcase
        probe_pixel(t.name, x, y, t.active, expected);
        if (errs == 0) begin
            pass_count++;
            $display("PASS %s", t.name);
        end else begin
            fail_count++;
            $display("FAIL %s (%0d errors)", t.name, errs);
        end
    endtask

    initial begin
        rst   = 1'b0;
        ctrl  = K_NONE;
        vsync = 1'b0;
        px    = '0;
        fill_table();
        cycle_limit = 200;
        foreach (tests[i]) begin
            cycle_limit += tests[i].frames * 6;
        end
        foreach (tests[i]) begin
            run_test(tests[i]);
        end
        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
                 pass_count, fail_count, DUT.u_props.prop_errors);
        if (fail_count == 0 && DUT.u_props.prop_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
